// File: hdl/tcb_pkg.sv
/* TCB protocol definitions */

`default_nettype none

package tcb_pkg;

  //////////////////////////////////////////////////////////////////////
  // bus widths
  //////////////////////////////////////////////////////////////////////

  // byte address width
  localparam int unsigned TCB_ABW = 16;
  // byte lanes per data word
  localparam int unsigned TCB_BEW = 4;
  // bits per byte lane
  localparam int unsigned TCB_SLW = 8;
  // data word width
  localparam int unsigned TCB_DBW = TCB_BEW * TCB_SLW;

  // fixed response delay after a transfer, in cycles
  localparam int unsigned TCB_DLY = 1;

  //////////////////////////////////////////////////////////////////////
  // channel payloads
  //////////////////////////////////////////////////////////////////////

  // request, held stable while vld && !rdy
  typedef struct packed {
    logic               wen;  // 1 = write, 0 = read
    logic [TCB_ABW-1:0] adr;  // byte address
    logic [TCB_BEW-1:0] ben;  // one enable per lane
    logic [TCB_DBW-1:0] wdt;  // write data
  } tcb_req_t;

  // response, strobed TCB_DLY cycles after the transfer
  typedef struct packed {
    logic [TCB_DBW-1:0] rdt;  // read data
    logic               err;  // decode error
  } tcb_rsp_t;

endpackage

`default_nettype wire

// File: hdl/tcb_map_pkg.sv
/* memory subsystem address map */

`default_nettype none

package tcb_map_pkg;

  // number of banks
  localparam int unsigned MAP_NUM = 4;
  // word address bits per bank, 256 words
  localparam int unsigned MAP_AW = 8;
  // bank select width
  localparam int unsigned MAP_SW = $clog2(MAP_NUM);
  // byte offset inside a word
  localparam int unsigned MAP_OW = $clog2(tcb_pkg::TCB_BEW);
  // leftover high address bits, must be zero for a mapped access
  localparam int unsigned MAP_HW = tcb_pkg::TCB_ABW - MAP_SW - MAP_AW - MAP_OW;
  // first byte address past the map
  localparam int unsigned MAP_END = MAP_NUM << (MAP_AW + MAP_OW);

  // routing view of an address, msb first
  typedef struct packed {
    logic [MAP_HW-1:0] hgh;  // out of map when nonzero
    logic [MAP_SW-1:0] sel;  // bank
    logic [MAP_AW-1:0] idx;  // word inside bank
    logic [MAP_OW-1:0] off;  // byte inside word
  } map_fld_t;

  // one address word, read as a number or as fields
  typedef union packed {
    logic [tcb_pkg::TCB_ABW-1:0] flat;
    map_fld_t                    fld;
  } map_adr_u;

endpackage

`default_nettype wire

// File: hdl/tcb_dec.sv
/* TCB request decoder */

`timescale 1ns/1ps
`default_nettype none

module tcb_dec (
  input  logic                                tcb,
  input  logic                                reset,
  // manager request
  input  tcb_pkg::tcb_req_t                   req,
  input  logic                                req_vld,
  output logic                                req_rdy,
  // bank requests
  output logic [tcb_map_pkg::MAP_NUM-1:0]     bank_vld,
  output tcb_pkg::tcb_req_t                   bank_req,
  input  logic [tcb_map_pkg::MAP_NUM-1:0]     bank_rdy,
  // transfer info for the response path
  output logic                                trn,
  output logic [tcb_map_pkg::MAP_SW-1:0]      trn_sel,
  output logic                                trn_err
);

  //////////////////////////////////////////////////////////////////////
  // address views
  //////////////////////////////////////////////////////////////////////

  tcb_map_pkg::map_adr_u adr;
  logic                  adr_ok;

  assign adr = req.adr;

  // flat compare against map end
  // same as high part being zero
  assign adr_ok = (adr.flat < tcb_map_pkg::MAP_END);

  //////////////////////////////////////////////////////////////////////
  // routing
  //////////////////////////////////////////////////////////////////////

  // payload is broadcast, only the valid is steered
  assign bank_req = req;

  // one valid per bank
  always_comb begin
    for (int i = 0; i < tcb_map_pkg::MAP_NUM; i++) begin
      bank_vld[i] = req_vld && adr_ok &&
                    (adr.fld.sel == tcb_map_pkg::MAP_SW'(i));
    end
  end

  // stall follows the addressed bank
  // unmapped requests are accepted right away
  assign req_rdy = adr_ok ? bank_rdy[adr.fld.sel] : 1'b1;

  //////////////////////////////////////////////////////////////////////
  // transfer info
  //////////////////////////////////////////////////////////////////////

  // handshake on the manager side
  assign trn = req_vld & req_rdy;

  // bank choice and error come from this decode only
  assign trn_sel = adr.fld.sel;
  assign trn_err = ~adr_ok;

  //////////////////////////////////////////////////////////////////////
  // checks
  //////////////////////////////////////////////////////////////////////

  // never two banks addressed at once
  bank_vld_onehot: assert property (
    @(posedge tcb) disable iff (reset)
    $onehot0(bank_vld)
  );

endmodule

`default_nettype wire

// File: hdl/tcb_mem.sv
/* TCB memory bank */

`timescale 1ns/1ps
`default_nettype none

module tcb_mem (
  input  logic              tcb,
  input  logic              reset,
  // request
  input  logic              vld,
  input  tcb_pkg::tcb_req_t req,
  output logic              rdy,
  // response
  output tcb_pkg::tcb_rsp_t rsp
);

  //////////////////////////////////////////////////////////////////////
  // storage
  //////////////////////////////////////////////////////////////////////

  localparam int unsigned DEPTH = 2 ** tcb_map_pkg::MAP_AW;

  // word array, lanes addressable
  logic [tcb_pkg::TCB_BEW-1:0][tcb_pkg::TCB_SLW-1:0] mem [DEPTH];

  // read data register
  logic [tcb_pkg::TCB_DBW-1:0] rdt;

  // word index from the address fields
  tcb_map_pkg::map_adr_u adr;
  logic                  trn;

  assign adr = req.adr;

  //////////////////////////////////////////////////////////////////////
  // handshake
  //////////////////////////////////////////////////////////////////////

  // no wait states
  assign rdy = 1'b1;
  assign trn = vld & rdy;

  //////////////////////////////////////////////////////////////////////
  // access
  //////////////////////////////////////////////////////////////////////

  // write at the transfer edge, enabled lanes only
  always_ff @(posedge tcb) begin
    if (trn && req.wen) begin
      for (int b = 0; b < tcb_pkg::TCB_BEW; b++) begin
        if (req.ben[b]) begin
          mem[adr.fld.idx][b] <= req.wdt[b*tcb_pkg::TCB_SLW +: tcb_pkg::TCB_SLW];
        end
      end
    end
  end

  // read registered, one cycle latency
  // left alone on writes, so the last read stays visible
  always_ff @(posedge tcb) begin
    if (trn && !req.wen) begin
      rdt <= mem[adr.fld.idx];
    end
  end

  // a bank never flags errors
  assign rsp.rdt = rdt;
  assign rsp.err = 1'b0;

  //////////////////////////////////////////////////////////////////////
  // checks
  //////////////////////////////////////////////////////////////////////

  // a write with no lanes enabled is a manager bug
  wr_has_ben: assert property (
    @(posedge tcb) disable iff (reset)
    (trn && req.wen) |-> (req.ben != '0)
  );

endmodule

`default_nettype wire

// File: hdl/tcb_rsp_mux.sv
/* TCB response multiplexer */

`timescale 1ns/1ps
`default_nettype none

module tcb_rsp_mux (
  input  logic                           tcb,
  input  logic                           reset,
  // transfer info from the decoder
  input  logic                           trn,
  input  logic [tcb_map_pkg::MAP_SW-1:0] trn_sel,
  input  logic                           trn_err,
  // bank responses
  input  tcb_pkg::tcb_rsp_t              bank_rsp [tcb_map_pkg::MAP_NUM],
  // manager response
  output tcb_pkg::tcb_rsp_t              rsp,
  output logic                           rsp_vld
);

  // one stage of the routing pipeline
  typedef struct packed {
    logic                           trn;
    logic [tcb_map_pkg::MAP_SW-1:0] sel;
    logic                           err;
  } stg_t;

  localparam int unsigned LST = tcb_pkg::TCB_DLY - 1;

  stg_t pip [tcb_pkg::TCB_DLY];

  //////////////////////////////////////////////////////////////////////
  // routing delay, matches bank read latency
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge tcb) begin
    if (reset) begin
      for (int i = 0; i < tcb_pkg::TCB_DLY; i++) begin
        pip[i] <= '0;
      end
    end else begin
      pip[0] <= '{trn: trn, sel: trn_sel, err: trn_err};
      // deeper stages, empty loop when delay is 1
      for (int i = 1; i < tcb_pkg::TCB_DLY; i++) begin
        pip[i] <= pip[i-1];
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // output select
  //////////////////////////////////////////////////////////////////////

  assign rsp_vld = pip[LST].trn;

  // decode error answers with zero data
  assign rsp = pip[LST].err ? tcb_pkg::tcb_rsp_t'{rdt: '0, err: 1'b1}
                            : bank_rsp[pip[LST].sel];

  // pipeline comes out of reset empty
  no_rsp_after_rst: assert property (
    @(posedge tcb)
    reset |=> !rsp_vld
  );

endmodule

`default_nettype wire

// File: hdl/tcb_sys.sv
/* TCB memory subsystem */

`timescale 1ns/1ps
`default_nettype none

module tcb_sys (
  input  logic              tcb,
  input  logic              reset,
  // request channel
  input  tcb_pkg::tcb_req_t req,
  input  logic              req_vld,
  output logic              req_rdy,
  // response channel
  output tcb_pkg::tcb_rsp_t rsp,
  output logic              rsp_vld
);

  //////////////////////////////////////////////////////////////////////
  // internal buses
  //////////////////////////////////////////////////////////////////////

  logic [tcb_map_pkg::MAP_NUM-1:0] bank_vld;
  tcb_pkg::tcb_req_t               bank_req;
  logic [tcb_map_pkg::MAP_NUM-1:0] bank_rdy;
  tcb_pkg::tcb_rsp_t               bank_rsp [tcb_map_pkg::MAP_NUM];

  // transfer info toward the response side
  logic                            trn;
  logic [tcb_map_pkg::MAP_SW-1:0]  trn_sel;
  logic                            trn_err;

  //////////////////////////////////////////////////////////////////////
  // request decode
  //////////////////////////////////////////////////////////////////////

  tcb_dec dec_i (
    .tcb      (tcb),
    .reset    (reset),
    .req      (req),
    .req_vld  (req_vld),
    .req_rdy  (req_rdy),
    .bank_vld (bank_vld),
    .bank_req (bank_req),
    .bank_rdy (bank_rdy),
    .trn      (trn),
    .trn_sel  (trn_sel),
    .trn_err  (trn_err)
  );

  // banks, all alike
  for (genvar i = 0; i < tcb_map_pkg::MAP_NUM; i++) begin : gen_bank
    tcb_mem mem_i (
      .tcb   (tcb),
      .reset (reset),
      .vld   (bank_vld[i]),
      .req   (bank_req),
      .rdy   (bank_rdy[i]),
      .rsp   (bank_rsp[i])
    );
  end

  // response return
  tcb_rsp_mux mux_i (
    .tcb      (tcb),
    .reset    (reset),
    .trn      (trn),
    .trn_sel  (trn_sel),
    .trn_err  (trn_err),
    .bank_rsp (bank_rsp),
    .rsp      (rsp),
    .rsp_vld  (rsp_vld)
  );

endmodule

`default_nettype wire

// File: tests/tcb_vip_dev.sv
/* TCB manager bus driver */

`timescale 1ns/1ps
`default_nettype none

module tcb_vip_dev (
  input  logic              tcb,
  input  logic              reset,
  // request channel, driven here
  output tcb_pkg::tcb_req_t req,
  output logic              req_vld,
  input  logic              req_rdy,
  // response channel, observed here
  input  tcb_pkg::tcb_rsp_t rsp,
  input  logic              rsp_vld
);

  //////////////////////////////////////////////////////////////////////
  // bookkeeping
  //////////////////////////////////////////////////////////////////////

  // issued transfers, oldest first
  tcb_pkg::tcb_req_t trn_req [$];
  // cycle stamp of each transfer edge
  int unsigned       trn_cyc [$];

  // free running cycle count
  int unsigned cyc;
  // cycles spent waiting on req_rdy
  int unsigned bp_cnt;
  // idle cycles inserted before requests
  int unsigned idle_cnt;

  // bus idle from time zero
  initial begin
    req     <= '0;
    req_vld <= 1'b0;
  end

  always @(posedge tcb) begin
    if (reset) begin
      cyc <= 0;
    end else begin
      cyc <= cyc + 1;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // request side
  //////////////////////////////////////////////////////////////////////

  // random idle gap, then hold the request until accepted
  // entered and left on a rising edge
  task automatic req_issue(input tcb_pkg::tcb_req_t r, input int unsigned max_idle);
    int unsigned idle;
    idle = $urandom_range(max_idle, 0);
    idle_cnt += idle;
    repeat (idle) begin
      req_vld <= 1'b0;
      @(posedge tcb);
    end
    req     <= r;
    req_vld <= 1'b1;
    do begin
      @(posedge tcb);
      // stalled edge
      if (req_rdy !== 1'b1) begin
        bp_cnt++;
      end
    end while (req_rdy !== 1'b1);
    trn_req.push_back(r);
    trn_cyc.push_back(cyc);
  endtask

  // drop valid after the last request
  task automatic req_stop();
    req_vld <= 1'b0;
  endtask

  //////////////////////////////////////////////////////////////////////
  // response side
  //////////////////////////////////////////////////////////////////////

  // next response strobe and its cycle stamp
  task automatic rsp_get(output tcb_pkg::tcb_rsp_t r, output int unsigned c);
    do begin
      @(posedge tcb);
    end while (rsp_vld !== 1'b1);
    r = rsp;
    c = cyc;
  endtask

  // oldest outstanding transfer
  task automatic trn_pop(output tcb_pkg::tcb_req_t r, output int unsigned c, output bit ok);
    ok = (trn_req.size() != 0);
    if (ok) begin
      r = trn_req.pop_front();
      c = trn_cyc.pop_front();
    end else begin
      r = '0;
      c = 0;
    end
  endtask

  function automatic int unsigned pending();
    return trn_req.size();
  endfunction

endmodule

`default_nettype wire

// File: tests/tcb_sys_tb.sv
/* TCB memory subsystem testbench */

`timescale 1ns/1ps
`default_nettype none

module tcb_sys_tb;

  typedef logic [tcb_pkg::TCB_ABW-1:0] adr_t;
  typedef logic [tcb_pkg::TCB_DBW-1:0] dat_t;
  typedef logic [tcb_pkg::TCB_BEW-1:0] ben_t;

  localparam int unsigned MAX_IDLE = 3;
  // one write per word of every bank
  localparam int unsigned N_FILL = tcb_map_pkg::MAP_NUM << tcb_map_pkg::MAP_AW;
  localparam int unsigned N_DIR  = 160;
  localparam int unsigned N_RAND = 400;
  // worst case cycles plus slack for drains and reset
  localparam longint unsigned WDOG_NS =
    (longint'(N_FILL + N_DIR + N_RAND) * (MAX_IDLE + 1) + 400) * 20;

  logic              tcb = 1'b0;
  logic              reset;
  tcb_pkg::tcb_req_t req;
  logic              req_vld;
  logic              req_rdy;
  tcb_pkg::tcb_rsp_t rsp;
  logic              rsp_vld;

  // byte model of the whole mapped range
  logic [tcb_pkg::TCB_SLW-1:0] mdl [tcb_map_pkg::MAP_END];

  string       test_name = "reset";
  int unsigned n_trn;
  int unsigned n_rsp;

  // 20 ns period
  always #10 tcb = ~tcb;

  tcb_sys tcb_sys_i (
    .tcb     (tcb),
    .reset   (reset),
    .req     (req),
    .req_vld (req_vld),
    .req_rdy (req_rdy),
    .rsp     (rsp),
    .rsp_vld (rsp_vld)
  );

  tcb_vip_dev dev_i (
    .tcb     (tcb),
    .reset   (reset),
    .req     (req),
    .req_vld (req_vld),
    .req_rdy (req_rdy),
    .rsp     (rsp),
    .rsp_vld (rsp_vld)
  );

  //////////////////////////////////////////////////////////////////////
  // failure handling and compare tasks
  //////////////////////////////////////////////////////////////////////

  task automatic abort_run(input string why);
    $display("TEST FAILED");
    $fatal(1, "%s", why);
  endtask

  task automatic check_rdt(input string name, input tcb_pkg::tcb_rsp_t exp,
                           input tcb_pkg::tcb_rsp_t act);
    if (act.rdt !== exp.rdt) begin
      $display("Mismatch %s rdt: expected %h, actual %h", name, exp.rdt, act.rdt);
      abort_run("read data differs from the model");
    end
  endtask

  task automatic check_err(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("Mismatch %s err: expected %b, actual %b", name, exp, act);
      abort_run("error flag differs from the model");
    end
  endtask

  // response cycle against transfer cycle
  task automatic check_lat(input string name, input int unsigned exp, input int unsigned act);
    if (act != exp) begin
      $display("Mismatch %s rsp cycle: expected %0d, actual %0d", name, exp, act);
      abort_run("response came at the wrong cycle");
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // memory model
  //////////////////////////////////////////////////////////////////////

  // mapped only when the high part is clear
  function automatic logic in_map(input adr_t adr);
    tcb_map_pkg::map_adr_u u;
    u = adr;
    return (u.fld.hgh == '0);
  endfunction

  // first byte of the addressed word
  function automatic int unsigned word_base(input adr_t adr);
    tcb_map_pkg::map_adr_u u;
    u = adr;
    u.fld.off = '0;
    return 32'(u.flat);
  endfunction

  function automatic dat_t mdl_word(input adr_t adr);
    dat_t        w;
    int unsigned base;
    base = word_base(adr);
    for (int b = 0; b < tcb_pkg::TCB_BEW; b++) begin
      w[b*tcb_pkg::TCB_SLW +: tcb_pkg::TCB_SLW] = mdl[base + b];
    end
    return w;
  endfunction

  // enabled lanes only
  task automatic mdl_write(input tcb_pkg::tcb_req_t r);
    int unsigned base;
    base = word_base(r.adr);
    for (int b = 0; b < tcb_pkg::TCB_BEW; b++) begin
      if (r.ben[b]) begin
        mdl[base + b] = r.wdt[b*tcb_pkg::TCB_SLW +: tcb_pkg::TCB_SLW];
      end
    end
  endtask

  // in order response check
  initial begin : rsp_check
    tcb_pkg::tcb_rsp_t got;
    tcb_pkg::tcb_rsp_t exp;
    tcb_pkg::tcb_req_t r;
    int unsigned       rc;
    int unsigned       tc;
    bit                ok;
    forever begin
      dev_i.rsp_get(got, rc);
      dev_i.trn_pop(r, tc, ok);
      if (!ok) begin
        abort_run("response strobe seen with no transfer outstanding");
      end
      check_lat(test_name, tc + tcb_pkg::TCB_DLY, rc);
      exp = '0;
      if (!in_map(r.adr)) begin
        // unmapped, err with zero data
        exp.err = 1'b1;
        check_err(test_name, 1'b1, got.err);
        check_rdt(test_name, exp, got);
      end else if (r.wen) begin
        check_err(test_name, 1'b0, got.err);
        mdl_write(r);
      end else begin
        exp.rdt = mdl_word(r.adr);
        check_err(test_name, 1'b0, got.err);
        check_rdt(test_name, exp, got);
      end
      n_rsp++;
    end
  end

  // hard stop on a hung bus
  initial begin : watchdog
    #(WDOG_NS);
    abort_run("timeout, the run did not finish within the expected time");
  end

  //////////////////////////////////////////////////////////////////////
  // stimulus helpers
  //////////////////////////////////////////////////////////////////////

  function automatic tcb_pkg::tcb_req_t mk_req(input logic wen, input adr_t adr,
                                               input ben_t ben, input dat_t wdt);
    tcb_pkg::tcb_req_t r;
    r.wen = wen;
    r.adr = adr;
    r.ben = ben;
    r.wdt = wdt;
    return r;
  endfunction

  // aligned byte address of a bank word
  function automatic adr_t map_adr(input int unsigned bank, input int unsigned idx);
    tcb_map_pkg::map_adr_u u;
    u = '0;
    u.fld.sel = tcb_map_pkg::MAP_SW'(bank);
    u.fld.idx = tcb_map_pkg::MAP_AW'(idx);
    return u.flat;
  endfunction

  function automatic adr_t rand_adr();
    return map_adr($urandom_range(tcb_map_pkg::MAP_NUM - 1, 0),
                   $urandom_range((1 << tcb_map_pkg::MAP_AW) - 1, 0));
  endfunction

  // same word, nonzero high part
  function automatic adr_t unmap_adr(input adr_t adr);
    tcb_map_pkg::map_adr_u u;
    u = adr;
    u.fld.hgh = tcb_map_pkg::MAP_HW'($urandom_range((1 << tcb_map_pkg::MAP_HW) - 1, 1));
    return u.flat;
  endfunction

  task automatic send(input tcb_pkg::tcb_req_t r, input int unsigned max_idle);
    dev_i.req_issue(r, max_idle);
    n_trn++;
  endtask

  // wait for every outstanding response
  task automatic drain();
    dev_i.req_stop();
    do begin
      @(posedge tcb);
    end while (dev_i.pending() != 0);
    @(posedge tcb);
  endtask

  //////////////////////////////////////////////////////////////////////
  // test sequence
  //////////////////////////////////////////////////////////////////////

  initial begin : main
    adr_t a;
    adr_t e;
    dat_t d;
    logic w;
    void'($urandom(49));
    reset <= 1'b1;
    repeat (3) @(posedge tcb);
    reset <= 1'b0;
    @(posedge tcb);

    // fill back to back, pattern from the whole address
    test_name = "fill";
    for (int unsigned i = 0; i < N_FILL; i++) begin
      a = adr_t'(i * tcb_pkg::TCB_BEW);
      send(mk_req(1'b1, a, '1, {a, ~a}), 0);
    end
    drain();

    // write then read back, every bank
    test_name = "wr_rd_bank";
    for (int unsigned b = 0; b < tcb_map_pkg::MAP_NUM; b++) begin
      for (int k = 0; k < 2; k++) begin
        a = map_adr(b, $urandom_range((1 << tcb_map_pkg::MAP_AW) - 1, 0));
        send(mk_req(1'b1, a, '1, $urandom), 1);
        send(mk_req(1'b0, a, '1, '0), 1);
      end
    end
    drain();

    // partial lanes keep the rest of the word
    test_name = "partial_ben";
    for (int unsigned b = 0; b < tcb_map_pkg::MAP_NUM; b++) begin
      for (int k = 0; k < 4; k++) begin
        a = map_adr(b, $urandom_range((1 << tcb_map_pkg::MAP_AW) - 1, 0));
        send(mk_req(1'b1, a, ben_t'($urandom_range(14, 1)), $urandom), 1);
        send(mk_req(1'b0, a, '1, '0), 1);
      end
    end
    drain();

    // unmapped write must not alias onto the low word
    test_name = "decode_err";
    for (int k = 0; k < 4; k++) begin
      a = rand_adr();
      e = unmap_adr(a);
      send(mk_req(1'b1, e, '1, $urandom), 1);
      send(mk_req(1'b0, e, '1, '0), 1);
      send(mk_req(1'b0, a, '1, '0), 1);
    end
    drain();

    // zero idle, one response per edge
    test_name = "b2b_read";
    for (int k = 0; k < 64; k++) begin
      send(mk_req(1'b0, rand_adr(), '1, '0), 0);
    end
    drain();

    // random mix with occasional unmapped accesses
    test_name = "random";
    for (int k = 0; k < N_RAND; k++) begin
      a = rand_adr();
      if ($urandom_range(15, 0) == 0) begin
        a = unmap_adr(a);
      end
      w = ($urandom_range(1, 0) == 1);
      d = $urandom;
      if (w) begin
        send(mk_req(1'b1, a, ben_t'($urandom_range(15, 1)), d), MAX_IDLE);
      end else begin
        send(mk_req(1'b0, a, '1, '0), MAX_IDLE);
      end
    end
    drain();

    $display("transfers %0d, responses %0d, idle cycles %0d, stalled cycles %0d",
             n_trn, n_rsp, dev_i.idle_cnt, dev_i.bp_cnt);
    // banks never stall, so the request side never sees ready low
    if (dev_i.bp_cnt == 0) begin
      $display("TEST PASSED");
      $finish;
    end else begin
      abort_run("request ready dropped although every bank is always ready");
    end
  end

endmodule

`default_nettype wire

// File: flist.f
hdl/tcb_pkg.sv
hdl/tcb_map_pkg.sv
hdl/tcb_dec.sv
hdl/tcb_mem.sv
hdl/tcb_rsp_mux.sv
hdl/tcb_sys.sv
tests/tcb_vip_dev.sv
tests/tcb_sys_tb.sv

// File: Makefile
# Verilator build and run for the TCB memory subsystem

VERILATOR ?= verilator
TOP       ?= tcb_sys_tb
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
PASS_MSG  ?= TEST PASSED

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator, run, and check for the pass message"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FLIST OBJ_DIR VFLAGS PASS_MSG"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
